/* logic/core_types_pkg.sv */
// core-wide sizes shared by the load unit and its neighbours
// covers the physical register file, its banking and the load completion queue
// import into any block that sizes a PR tag, a bank index or a cq index

package core_types_pkg;

	// ---------------------------------------------------------------------
	// physical registers

	localparam int PR_COUNT = 64;
	localparam int LOG_PR_COUNT = $clog2(PR_COUNT);

	// ---------------------------------------------------------------------
	// register file banking

	// bank index is the low PR bits
	localparam int PRF_BANK_COUNT = 4;
	localparam int LOG_PRF_BANK_COUNT = $clog2(PRF_BANK_COUNT);

	// tag bits left once the bank index is stripped
	localparam int UPPER_PR_W = LOG_PR_COUNT - LOG_PRF_BANK_COUNT;

	// ---------------------------------------------------------------------
	// load completion queue

	localparam int LDU_CQ_ENTRIES = 16;
	localparam int LOG_LDU_CQ_ENTRIES = $clog2(LDU_CQ_ENTRIES);

endpackage

/* logic/ldu_iq_pkg.sv */
// types and sizes of the load-unit issue queue
// holds the enqueue, slot, writeback, issue and register-read payloads
// import wherever these structs cross a port or sit in a register

package ldu_iq_pkg;

	import core_types_pkg::*;

	// queue depth, also the default for the module parameters
	localparam int LDU_IQ_ENTRIES = 4;

	// ---------------------------------------------------------------------
	// enqueue from dispatch

	typedef struct packed {
		logic valid;
		logic [3:0] op;
		logic [11:0] imm12;
		logic [LOG_PR_COUNT-1:0] A_PR;
		logic A_ready;
		logic A_is_zero;
		logic [LOG_LDU_CQ_ENTRIES-1:0] cq_index;
	} ldu_iq_enq_t;

	// slot contents, valid marks an occupied slot
	typedef struct packed {
		logic valid;
		logic [3:0] op;
		logic [11:0] imm12;
		logic [LOG_PR_COUNT-1:0] A_PR;
		logic A_ready;
		logic A_is_zero;
		logic [LOG_LDU_CQ_ENTRIES-1:0] cq_index;
	} ldu_iq_entry_t;

	// ---------------------------------------------------------------------
	// writeback bus, one tag per register-file bank

	typedef struct packed {
		logic [PRF_BANK_COUNT-1:0] valid_by_bank;
		logic [PRF_BANK_COUNT-1:0][UPPER_PR_W-1:0] upper_PR_by_bank;
	} wb_bus_t;

	// ---------------------------------------------------------------------
	// issue to the load pipeline and read request to the PRF

	typedef struct packed {
		logic valid;
		logic [3:0] op;
		logic [11:0] imm12;
		logic A_forward;
		logic A_is_zero;
		logic [LOG_PRF_BANK_COUNT-1:0] A_bank;
		logic [LOG_LDU_CQ_ENTRIES-1:0] cq_index;
	} ldu_issue_t;

	typedef struct packed {
		logic valid;
		logic [LOG_PR_COUNT-1:0] PR;
	} prf_req_t;

endpackage

/* logic/pipe_reg.sv */
// single register stage for any packed payload
// cleared to zero by reset, then follows d with one cycle of delay
// set T to the payload type at each instance

`timescale 1ns/1ps

module pipe_reg #(
	parameter type T = logic
) (
	input logic CLK,
	input logic nRST,

	// stage input
	input T d,

	// stage output, one cycle later
	output T q
);

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			q <= '0;
		end else begin
			q <= d;
		end
	end

endmodule

/* logic/ldu_iq_entry.sv */
// one slot of the compressing load issue queue
// each cycle it keeps its load, takes its upper neighbour's or takes the enqueue
// shift and load come from the allocator, wakeup from the banked writeback bus

`timescale 1ns/1ps

module ldu_iq_entry (
	input logic CLK,
	input logic nRST,

	// allocator controls
	input logic shift,
	input logic load,

	// candidate sources
	input ldu_iq_pkg::ldu_iq_entry_t upper,
	input ldu_iq_pkg::ldu_iq_enq_t enq,

	// writeback tags
	input ldu_iq_pkg::wb_bus_t wb_bus,

	// slot status
	output ldu_iq_pkg::ldu_iq_entry_t state,
	output logic ready_now,
	output logic woken_now
);

	import core_types_pkg::*;
	import ldu_iq_pkg::*;

	ldu_iq_entry_t src;
	ldu_iq_entry_t state_next;
	logic state_hit;

	// bank picked by the low PR bits, then compare the rest of the tag
	function automatic logic tag_hit(input wb_bus_t wb, input logic [LOG_PR_COUNT-1:0] pr);
		logic [LOG_PRF_BANK_COUNT-1:0] bank;
		logic [UPPER_PR_W-1:0] upper_tag;
		bank = pr[LOG_PRF_BANK_COUNT-1:0];
		upper_tag = pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT];
		return wb.valid_by_bank[bank] && (wb.upper_PR_by_bank[bank] == upper_tag);
	endfunction

	// ---------------------------------------------------------------------
	// next contents

	always_comb begin
		if (load) begin
			src.valid = enq.valid;
			src.op = enq.op;
			src.imm12 = enq.imm12;
			src.A_PR = enq.A_PR;
			src.A_ready = enq.A_ready;
			src.A_is_zero = enq.A_is_zero;
			src.cq_index = enq.cq_index;
		end else if (shift) begin
			src = upper;
		end else begin
			src = state;
		end

		// wakeup applies to whatever gets written
		state_next = src;
		state_next.A_ready = src.A_ready | tag_hit(wb_bus, src.A_PR);
	end

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			state <= '0;
		end else begin
			state <= state_next;
		end
	end

	// ---------------------------------------------------------------------
	// readiness seen by the selector this cycle

	assign state_hit = tag_hit(wb_bus, state.A_PR);
	assign ready_now = state.valid & (state.A_ready | state.A_is_zero | state_hit);

	// operand only arrives on the bypass this cycle
	assign woken_now = state.valid & ~state.A_ready & state_hit;

	a_shift_load_excl: assert property (@(posedge CLK) disable iff (!nRST) !(shift && load))
		else $error("slot asked to shift and load in the same cycle");

endmodule

/* logic/ldu_iq_enq_alloc.sv */
// shift and load control for the compressing issue queue
// slots at or above the issued one pull from their upper neighbour
// the enqueue lands in the lowest slot still free after that shift

`timescale 1ns/1ps

module ldu_iq_enq_alloc #(
	parameter int LDU_IQ_ENTRIES = ldu_iq_pkg::LDU_IQ_ENTRIES
) (
	input logic [LDU_IQ_ENTRIES-1:0] valid_vec,
	input logic [LDU_IQ_ENTRIES-1:0] issue_sel,
	input logic enq_valid,
	output logic [LDU_IQ_ENTRIES-1:0] shift_vec,
	output logic [LDU_IQ_ENTRIES-1:0] load_vec,
	output logic enq_ready
);

	logic [LDU_IQ_ENTRIES-1:0] at_or_above;
	logic [LDU_IQ_ENTRIES-1:0] valid_upper;
	logic [LDU_IQ_ENTRIES-1:0] valid_after;

	// any free slot accepts, even one freed only by this cycle's issue is not counted
	assign enq_ready = ~&valid_vec;

	// occupancy one slot up, nothing above the top
	assign valid_upper = {1'b0, valid_vec[LDU_IQ_ENTRIES-1:1]};

	always_comb begin : shift_region
		at_or_above[0] = issue_sel[0];
		for (int i = 1; i < LDU_IQ_ENTRIES; i++) begin
			at_or_above[i] = at_or_above[i-1] | issue_sel[i];
		end
	end

	assign valid_after = (at_or_above & valid_upper) | (~at_or_above & valid_vec);

	always_comb begin : lowest_free
		logic found;
		found = 1'b0;
		load_vec = '0;
		for (int i = 0; i < LDU_IQ_ENTRIES; i++) begin
			if (!valid_after[i] && !found) begin
				load_vec[i] = enq_valid & enq_ready;
				found = 1'b1;
			end
		end
	end

	// a loaded slot takes the enqueue instead of its empty neighbour
	assign shift_vec = at_or_above & ~load_vec;

	always_comb begin
		a_load_onehot: assert final ($onehot0(load_vec))
			else $error("enqueue written into more than one slot");
		a_no_load_full: assert final (!((|load_vec) && (&valid_vec)))
			else $error("enqueue written while the queue was full");
	end

endmodule

/* logic/ldu_iq_issue_select.sv */
// issue choice for the load issue queue
// the lowest ready slot is the oldest, since the queue compresses toward 0
// also forms the pipeline issue fields and the register-file read request

`timescale 1ns/1ps

module ldu_iq_issue_select #(
	parameter int LDU_IQ_ENTRIES = ldu_iq_pkg::LDU_IQ_ENTRIES
) (
	// slot status
	input ldu_iq_pkg::ldu_iq_entry_t [LDU_IQ_ENTRIES-1:0] states,
	input logic [LDU_IQ_ENTRIES-1:0] ready_vec,
	input logic [LDU_IQ_ENTRIES-1:0] woken_vec,

	// load pipeline can take an op
	input logic pipeline_ready,

	// chosen slot, one-hot or zero
	output logic [LDU_IQ_ENTRIES-1:0] issue_sel,

	output ldu_iq_pkg::ldu_issue_t issue,
	output ldu_iq_pkg::prf_req_t prf_req
);

	import core_types_pkg::*;
	import ldu_iq_pkg::*;

	ldu_iq_entry_t picked;
	logic picked_woken;

	// ---------------------------------------------------------------------
	// oldest ready first

	always_comb begin : oldest_ready
		logic taken;
		taken = 1'b0;
		issue_sel = '0;
		for (int i = 0; i < LDU_IQ_ENTRIES; i++) begin
			if (pipeline_ready && ready_vec[i] && !taken) begin
				issue_sel[i] = 1'b1;
				taken = 1'b1;
			end
		end
	end

	// zero when nothing is picked
	always_comb begin : pick_mux
		picked = '0;
		picked_woken = 1'b0;
		for (int i = 0; i < LDU_IQ_ENTRIES; i++) begin
			if (issue_sel[i]) begin
				picked = states[i];
				picked_woken = woken_vec[i];
			end
		end
	end

	// ---------------------------------------------------------------------
	// outputs

	always_comb begin
		issue.valid = |issue_sel;
		issue.op = picked.op;
		issue.imm12 = picked.imm12;
		issue.A_forward = picked_woken;
		issue.A_is_zero = picked.A_is_zero;
		issue.A_bank = picked.A_PR[LOG_PRF_BANK_COUNT-1:0];
		issue.cq_index = picked.cq_index;

		// forwarded or zero operands skip the register file
		prf_req.valid = (|issue_sel) & ~picked.A_is_zero & ~picked_woken;
		prf_req.PR = picked.A_PR;
	end

	always_comb begin
		a_sel_onehot: assert final ($onehot0(issue_sel))
			else $error("more than one slot selected for issue");
	end

endmodule

/* logic/ldu_iq.sv */
// load-unit issue queue core
// compressing queue, slot 0 holds the oldest load
// allocator feeds the slots, the selector drains the oldest ready one
// all paths are combinational apart from the slot registers

`timescale 1ns/1ps

module ldu_iq #(
	parameter int LDU_IQ_ENTRIES = ldu_iq_pkg::LDU_IQ_ENTRIES
) (
	input logic CLK,
	input logic nRST,

	// enqueue from dispatch
	input ldu_iq_pkg::ldu_iq_enq_t enq,
	output logic enq_ready,

	// banked writeback tags
	input ldu_iq_pkg::wb_bus_t wb_bus,

	// load pipeline
	input logic pipeline_ready,
	output ldu_iq_pkg::ldu_issue_t issue,

	// register-file read
	output ldu_iq_pkg::prf_req_t prf_req
);

	import ldu_iq_pkg::*;

	ldu_iq_entry_t [LDU_IQ_ENTRIES-1:0] states;
	ldu_iq_entry_t [LDU_IQ_ENTRIES-1:0] uppers;

	logic [LDU_IQ_ENTRIES-1:0] valid_vec;
	logic [LDU_IQ_ENTRIES-1:0] ready_vec;
	logic [LDU_IQ_ENTRIES-1:0] woken_vec;
	logic [LDU_IQ_ENTRIES-1:0] shift_vec;
	logic [LDU_IQ_ENTRIES-1:0] load_vec;
	logic [LDU_IQ_ENTRIES-1:0] issue_sel;

	// ---------------------------------------------------------------------
	// allocation

	ldu_iq_enq_alloc #(
		.LDU_IQ_ENTRIES(LDU_IQ_ENTRIES)
	) alloc_inst (
		.valid_vec(valid_vec),
		.issue_sel(issue_sel),
		.enq_valid(enq.valid),
		.shift_vec(shift_vec),
		.load_vec(load_vec),
		.enq_ready(enq_ready)
	);

	// ---------------------------------------------------------------------
	// slots

	for (genvar i = 0; i < LDU_IQ_ENTRIES; i++) begin : g_slot
		// top slot shifts in an empty neighbour
		if (i == LDU_IQ_ENTRIES - 1) begin : g_top
			assign uppers[i] = '0;
		end else begin : g_inner
			assign uppers[i] = states[i+1];
		end

		assign valid_vec[i] = states[i].valid;

		ldu_iq_entry slot_inst (
			.CLK(CLK),
			.nRST(nRST),
			.shift(shift_vec[i]),
			.load(load_vec[i]),
			.upper(uppers[i]),
			.enq(enq),
			.wb_bus(wb_bus),
			.state(states[i]),
			.ready_now(ready_vec[i]),
			.woken_now(woken_vec[i])
		);
	end

	// ---------------------------------------------------------------------
	// issue

	ldu_iq_issue_select #(
		.LDU_IQ_ENTRIES(LDU_IQ_ENTRIES)
	) select_inst (
		.states(states),
		.ready_vec(ready_vec),
		.woken_vec(woken_vec),
		.pipeline_ready(pipeline_ready),
		.issue_sel(issue_sel),
		.issue(issue),
		.prf_req(prf_req)
	);

	// occupied slots stay packed at the bottom
	a_no_holes: assert property (@(posedge CLK) disable iff (!nRST)
		((valid_vec + 1'b1) & valid_vec) == '0)
		else $error("gap between occupied slots");

endmodule

/* logic/ldu_iq_wrapper.sv */
// top level around the load issue queue
// every port passes through one register stage, so the queue is timed alone
// next_ ports feed the input stages, last_ ports come from the output stages

`timescale 1ns/1ps

module ldu_iq_wrapper (
	input logic CLK,
	input logic nRST,

	input ldu_iq_pkg::ldu_iq_enq_t next_ldu_iq_enq,
	output logic last_ldu_iq_enq_ready,

	input ldu_iq_pkg::wb_bus_t next_wb_bus,

	output ldu_iq_pkg::ldu_issue_t last_issue,
	output ldu_iq_pkg::prf_req_t last_prf_req,

	input logic next_pipeline_ready
);

	import ldu_iq_pkg::*;

	ldu_iq_enq_t ldu_iq_enq;
	logic ldu_iq_enq_ready;
	wb_bus_t wb_bus;
	ldu_issue_t issue;
	prf_req_t prf_req;
	logic pipeline_ready;

	// ---------------------------------------------------------------------
	// input stages

	pipe_reg #(.T(ldu_iq_enq_t)) enq_reg (
		.CLK(CLK), .nRST(nRST), .d(next_ldu_iq_enq), .q(ldu_iq_enq)
	);

	pipe_reg #(.T(wb_bus_t)) wb_reg (
		.CLK(CLK), .nRST(nRST), .d(next_wb_bus), .q(wb_bus)
	);

	pipe_reg #(.T(logic)) pipeline_ready_reg (
		.CLK(CLK), .nRST(nRST), .d(next_pipeline_ready), .q(pipeline_ready)
	);

	// ---------------------------------------------------------------------
	// queue core

	ldu_iq #(
		.LDU_IQ_ENTRIES(LDU_IQ_ENTRIES)
	) ldu_iq_inst (
		.CLK(CLK),
		.nRST(nRST),
		.enq(ldu_iq_enq),
		.enq_ready(ldu_iq_enq_ready),
		.wb_bus(wb_bus),
		.pipeline_ready(pipeline_ready),
		.issue(issue),
		.prf_req(prf_req)
	);

	// ---------------------------------------------------------------------
	// output stages

	pipe_reg #(.T(logic)) enq_ready_reg (
		.CLK(CLK), .nRST(nRST), .d(ldu_iq_enq_ready), .q(last_ldu_iq_enq_ready)
	);

	pipe_reg #(.T(ldu_issue_t)) issue_reg (
		.CLK(CLK), .nRST(nRST), .d(issue), .q(last_issue)
	);

	pipe_reg #(.T(prf_req_t)) prf_req_reg (
		.CLK(CLK), .nRST(nRST), .d(prf_req), .q(last_prf_req)
	);

endmodule

/* tests/clk_gen.sv */
// clock and reset source for the load issue queue testbench
// free-running clock, reset held low for a fixed number of rising edges

`timescale 1ns/1ps

module clk_gen #(
	parameter int PERIOD_NS = 40,
	parameter int RESET_CYCLES = 4
) (
	output logic CLK,
	output logic nRST
);

	initial begin
		CLK = 1'b0;
		forever #(PERIOD_NS / 2) CLK = ~CLK;
	end

	// release on a rising edge, after the flops have seen reset
	initial begin
		nRST = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		nRST <= 1'b1;
	end

endmodule

/* tests/ldu_iq_tb.sv */
// testbench for the load issue queue wrapper
// a cycle model of the queue core predicts every registered output
// concurrent assertions on the falling edge compare the DUT against it
// directed tests first, then a random mix of loads, wakeups and back-pressure

`timescale 1ns/1ps

module ldu_iq_tb;

	import core_types_pkg::*;
	import ldu_iq_pkg::*;

	localparam int RAND_CYCLES = 300;
	localparam int TEST_CYCLES = 20 + 30 + 20 + 25 + 30 + RAND_CYCLES + 40;
	localparam int MAX_CYCLES = TEST_CYCLES + 200;

	logic CLK;
	logic nRST;
	ldu_iq_enq_t next_ldu_iq_enq;
	logic last_ldu_iq_enq_ready;
	wb_bus_t next_wb_bus;
	ldu_issue_t last_issue;
	prf_req_t last_prf_req;
	logic next_pipeline_ready;

	// model state, mirrors the core slots and its input registers
	ldu_iq_enq_t mq [LDU_IQ_ENTRIES];
	int mcount;
	ldu_iq_enq_t m_enq;
	wb_bus_t m_wb;
	logic m_prdy;
	ldu_issue_t exp_issue;
	prf_req_t exp_prf;
	logic exp_enq_ready;

	string test_name;
	int value_errs;
	int other_errs;
	int enq_sent;
	int issued_seen;
	int cycle_count;
	logic saw_full;
	logic [15:0] lfsr_state;
	logic [LOG_PR_COUNT-1:0] waiting_prs [$];

	clk_gen #(.PERIOD_NS(40), .RESET_CYCLES(4)) clk_gen_inst (.CLK(CLK), .nRST(nRST));

	ldu_iq_wrapper ldu_iq_wrapper_inst (
		.CLK(CLK),
		.nRST(nRST),
		.next_ldu_iq_enq(next_ldu_iq_enq),
		.last_ldu_iq_enq_ready(last_ldu_iq_enq_ready),
		.next_wb_bus(next_wb_bus),
		.last_issue(last_issue),
		.last_prf_req(last_prf_req),
		.next_pipeline_ready(next_pipeline_ready)
	);

	// ----------------------------------------------------------------------
	// helpers

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	function automatic logic wb_hits(input wb_bus_t wb, input logic [LOG_PR_COUNT-1:0] pr);
		logic hit;
		hit = 1'b0;
		for (int b = 0; b < PRF_BANK_COUNT; b++) begin
			if (wb.valid_by_bank[b] && pr[LOG_PRF_BANK_COUNT-1:0] == LOG_PRF_BANK_COUNT'(b)
					&& wb.upper_PR_by_bank[b] == pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT])
				hit = 1'b1;
		end
		return hit;
	endfunction

	function automatic wb_bus_t tag_bus(input logic [LOG_PR_COUNT-1:0] pr);
		wb_bus_t wb;
		wb = '0;
		wb.valid_by_bank[pr[LOG_PRF_BANK_COUNT-1:0]] = 1'b1;
		wb.upper_PR_by_bank[pr[LOG_PRF_BANK_COUNT-1:0]] = pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT];
		return wb;
	endfunction

	function automatic ldu_iq_enq_t make_load(input logic [3:0] op, input logic [11:0] imm,
			input logic [LOG_PR_COUNT-1:0] pr, input logic rdy, input logic zero,
			input logic [LOG_LDU_CQ_ENTRIES-1:0] cq);
		ldu_iq_enq_t e;
		e.valid = 1'b1;
		e.op = op;
		e.imm12 = imm;
		e.A_PR = pr;
		e.A_ready = rdy;
		e.A_is_zero = zero;
		e.cq_index = cq;
		return e;
	endfunction

	task automatic report_mismatch(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		value_errs++;
		$display("ERR %s: %s expected 0x%0h actual 0x%0h", test_name, what, expected, actual);
	endtask

	task automatic report_failure(input string msg);
		other_errs++;
		$display("%s", msg);
	endtask

	task automatic finish_run(input logic timed_out);
		$display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
		if (!timed_out && value_errs == 0 && other_errs == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	endtask

	task automatic drive_cycle(input ldu_iq_enq_t e, input wb_bus_t wb);
		@(posedge CLK);
		next_ldu_iq_enq <= e;
		next_wb_bus <= wb;
		if (e.valid)
			enq_sent++;
	endtask

	task automatic push_load(input logic [3:0] op, input logic [11:0] imm,
			input logic [LOG_PR_COUNT-1:0] pr, input logic rdy, input logic zero,
			input logic [LOG_LDU_CQ_ENTRIES-1:0] cq);
		drive_cycle(make_load(op, imm, pr, rdy, zero, cq), '0);
	endtask

	task automatic hold_pipeline(input logic rdy);
		drive_cycle('0, '0);
		next_pipeline_ready <= rdy;
	endtask

	// idle until the model is empty, waking any load still waiting
	task automatic drain();
		wb_bus_t wb;
		drive_cycle('0, '0);
		while (mcount != 0 || m_enq.valid || next_ldu_iq_enq.valid) begin
			wb = '0;
			if (waiting_prs.size() > 0)
				wb = tag_bus(waiting_prs.pop_front());
			drive_cycle('0, wb);
		end
		repeat (3) drive_cycle('0, '0);
	endtask

	task automatic random_cycle();
		ldu_iq_enq_t e;
		wb_bus_t wb;
		int occupancy;
		e = '0;
		wb = '0;
		@(posedge CLK);
		// loads already inside plus the two still in flight
		occupancy = mcount + int'(m_enq.valid) + int'(next_ldu_iq_enq.valid);
		if (occupancy <= LDU_IQ_ENTRIES - 2 && lfsr_bits(1) != 0) begin
			e.valid = 1'b1;
			e.op = 4'(lfsr_bits(4));
			e.imm12 = 12'(lfsr_bits(12));
			e.cq_index = LOG_LDU_CQ_ENTRIES'(lfsr_bits(LOG_LDU_CQ_ENTRIES));
			if (lfsr_bits(3) == 0) begin
				e.A_is_zero = 1'b1;
			end else begin
				e.A_PR = LOG_PR_COUNT'(lfsr_bits(LOG_PR_COUNT));
				e.A_ready = 1'(lfsr_bits(1));
				if (!e.A_ready)
					waiting_prs.push_back(e.A_PR);
			end
		end
		if (waiting_prs.size() > 0 && lfsr_bits(1) != 0)
			wb = tag_bus(waiting_prs.pop_front());
		else if (lfsr_bits(2) == 0)
			wb = tag_bus(LOG_PR_COUNT'(lfsr_bits(LOG_PR_COUNT)));
		next_ldu_iq_enq <= e;
		next_wb_bus <= wb;
		next_pipeline_ready <= (lfsr_bits(2) != 0);
		if (e.valid)
			enq_sent++;
	endtask

	// ----------------------------------------------------------------------
	// reference model of the queue core, one step per clock

	always @(posedge CLK) begin : ref_model
		ldu_iq_enq_t nq [LDU_IQ_ENTRIES];
		ldu_issue_t iss;
		prf_req_t req;
		int sel;
		int n;
		if (!nRST) begin
			for (int i = 0; i < LDU_IQ_ENTRIES; i++)
				mq[i] <= '0;
			mcount <= 0;
			m_enq <= '0;
			m_wb <= '0;
			m_prdy <= 1'b0;
			exp_issue <= '0;
			exp_prf <= '0;
			exp_enq_ready <= 1'b0;
		end else begin
			sel = -1;
			iss = '0;
			req = '0;
			for (int i = 0; i < LDU_IQ_ENTRIES; i++) begin
				if (m_prdy && sel < 0 && i < mcount
						&& (mq[i].A_ready || mq[i].A_is_zero || wb_hits(m_wb, mq[i].A_PR)))
					sel = i;
			end
			if (sel >= 0) begin
				iss.valid = 1'b1;
				iss.op = mq[sel].op;
				iss.imm12 = mq[sel].imm12;
				iss.A_forward = !mq[sel].A_ready && wb_hits(m_wb, mq[sel].A_PR);
				iss.A_is_zero = mq[sel].A_is_zero;
				iss.A_bank = mq[sel].A_PR[LOG_PRF_BANK_COUNT-1:0];
				iss.cq_index = mq[sel].cq_index;
				req.valid = !iss.A_is_zero && !iss.A_forward;
				req.PR = mq[sel].A_PR;
			end
			// survivors keep their order, the enqueue goes on top
			n = 0;
			for (int i = 0; i < LDU_IQ_ENTRIES; i++) begin
				if (i < mcount && i != sel) begin
					nq[n] = mq[i];
					nq[n].A_ready = nq[n].A_ready | wb_hits(m_wb, nq[n].A_PR);
					n++;
				end
			end
			if (m_enq.valid && mcount < LDU_IQ_ENTRIES) begin
				nq[n] = m_enq;
				nq[n].A_ready = nq[n].A_ready | wb_hits(m_wb, nq[n].A_PR);
				n++;
			end
			for (int i = 0; i < LDU_IQ_ENTRIES; i++)
				mq[i] <= (i < n) ? nq[i] : '0;
			mcount <= n;
			exp_issue <= iss;
			exp_prf <= req;
			exp_enq_ready <= (mcount < LDU_IQ_ENTRIES);
			m_enq <= next_ldu_iq_enq;
			m_wb <= next_wb_bus;
			m_prdy <= next_pipeline_ready;
		end
	end

	// ----------------------------------------------------------------------
	// checks, on the falling edge where every output is settled

	a_issue_valid: assert property (@(negedge CLK) disable iff (!nRST)
		last_issue.valid == exp_issue.valid)
		else report_mismatch("issue valid", 32'(exp_issue.valid), 32'(last_issue.valid));

	a_issue_fields: assert property (@(negedge CLK) disable iff (!nRST)
		!exp_issue.valid || last_issue == exp_issue)
		else report_mismatch("issue", 32'(exp_issue), 32'(last_issue));

	a_prf_valid: assert property (@(negedge CLK) disable iff (!nRST)
		last_prf_req.valid == exp_prf.valid)
		else report_mismatch("prf_req valid", 32'(exp_prf.valid), 32'(last_prf_req.valid));

	a_prf_pr: assert property (@(negedge CLK) disable iff (!nRST)
		!exp_prf.valid || last_prf_req.PR == exp_prf.PR)
		else report_mismatch("prf_req PR", 32'(exp_prf.PR), 32'(last_prf_req.PR));

	a_enq_ready: assert property (@(negedge CLK) disable iff (!nRST)
		last_ldu_iq_enq_ready == exp_enq_ready)
		else report_mismatch("enq_ready", 32'(exp_enq_ready), 32'(last_ldu_iq_enq_ready));

	a_reset_quiet: assert property (@(negedge CLK)
		!nRST |-> (!last_issue.valid && !last_prf_req.valid && !last_ldu_iq_enq_ready))
		else report_failure("an output valid or enqueue ready was set during reset");

	always @(negedge CLK) begin
		if (nRST && last_issue.valid)
			issued_seen++;
		if (nRST && test_name == "backpressure" && !last_ldu_iq_enq_ready)
			saw_full = 1'b1;
	end

	always @(posedge CLK) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES) begin
			report_failure("run stopped at the cycle limit before the queue drained");
			finish_run(1'b1);
		end
	end

	// ----------------------------------------------------------------------
	// test sequence

	initial begin
		wb_bus_t wrong_tag;
		test_name = "reset";
		lfsr_state = 16'd19657;
		value_errs = 0;
		other_errs = 0;
		enq_sent = 0;
		issued_seen = 0;
		cycle_count = 0;
		saw_full = 1'b0;
		next_ldu_iq_enq <= '0;
		next_wb_bus <= '0;
		next_pipeline_ready <= 1'b0;
		@(posedge nRST);
		hold_pipeline(1'b1);

		test_name = "ready_load";
		push_load(4'h3, 12'h0a5, 6'h17, 1'b1, 1'b0, 4'h2);
		drain();

		// wrong tags first, same bank and same upper bits on another bank
		test_name = "wakeup";
		push_load(4'h5, 12'h321, 6'h2d, 1'b0, 1'b0, 4'h7);
		repeat (4) drive_cycle('0, '0);
		wrong_tag = '0;
		wrong_tag.valid_by_bank = 4'b0110;
		wrong_tag.upper_PR_by_bank[1] = 4'ha;
		wrong_tag.upper_PR_by_bank[2] = 4'hb;
		drive_cycle('0, wrong_tag);
		repeat (4) drive_cycle('0, '0);
		drive_cycle('0, tag_bus(6'h2d));
		drain();

		test_name = "zero_reg";
		push_load(4'h1, 12'h800, 6'h00, 1'b0, 1'b1, 4'h9);
		drain();

		test_name = "oldest_first";
		hold_pipeline(1'b0);
		push_load(4'h2, 12'h010, 6'h21, 1'b1, 1'b0, 4'h3);
		push_load(4'h6, 12'h020, 6'h12, 1'b1, 1'b0, 4'h4);
		push_load(4'h9, 12'h030, 6'h3f, 1'b1, 1'b0, 4'h5);
		repeat (2) drive_cycle('0, '0);
		hold_pipeline(1'b1);
		drain();

		test_name = "backpressure";
		hold_pipeline(1'b0);
		push_load(4'ha, 12'h111, 6'h04, 1'b1, 1'b0, 4'ha);
		push_load(4'hb, 12'h222, 6'h09, 1'b1, 1'b0, 4'hb);
		push_load(4'hc, 12'h333, 6'h0e, 1'b1, 1'b0, 4'hc);
		push_load(4'hd, 12'h444, 6'h13, 1'b1, 1'b0, 4'hd);
		// full shows on the registered enq_ready a few cycles after the last push
		for (int w = 0; w < 8 && !saw_full; w++)
			drive_cycle('0, '0);
		repeat (2) drive_cycle('0, '0);
		hold_pipeline(1'b1);
		drain();

		test_name = "random";
		for (int c = 0; c < RAND_CYCLES; c++)
			random_cycle();
		hold_pipeline(1'b1);
		drain();

		a_none_lost: assert (issued_seen == enq_sent)
			else report_failure($sformatf("%0d loads enqueued but %0d issued",
				enq_sent, issued_seen));
		a_filled: assert (saw_full)
			else report_failure("queue never reported full under back-pressure");
		finish_run(1'b0);
	end

endmodule

/* files.f */
logic/core_types_pkg.sv
logic/ldu_iq_pkg.sv
logic/pipe_reg.sv
logic/ldu_iq_entry.sv
logic/ldu_iq_enq_alloc.sv
logic/ldu_iq_issue_select.sv
logic/ldu_iq.sv
logic/ldu_iq_wrapper.sv
tests/clk_gen.sv
tests/ldu_iq_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the load issue queue testbench with Verilator and runs it
# exits non-zero if the build fails, the run fails or the pass line is missing

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
	--top-module ldu_iq_tb -o ldu_iq_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/ldu_iq_sim)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "PASS: all tests"; then
	exit 0
fi

echo "pass line not found in simulation output"
exit 1
